//--- verilog/line_rev_pkg.sv
package line_rev_pkg;

	localparam int PIX_W   = 8;
	localparam int ADDR_W  = 15;
	localparam int NUM_RAM = 4;
	// read latency of the line rams in cycles
	localparam int RAM_LAT = 2;

	typedef logic [PIX_W-1:0]  pix_t;
	typedef logic [ADDR_W-1:0] addr_t;

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_DELAY,
		ST_SEG1,
		ST_SEG2,
		ST_DRAIN,
		ST_ACK
	} seq_state_t;

	// one slot from the sequencer, read or drain marker
	typedef struct packed
	{
		logic  rd;
		logic  seg;
		logic  bank;
		logic  drain;
		addr_t addr_fwd;
		addr_t addr_rev;
	} rd_cmd_t;

	typedef struct packed
	{
		logic [NUM_RAM-1:0] en;
		logic               bank;
		addr_t              addr_fwd;
		addr_t              addr_rev;
	} ram_rd_t;

	// pix[i] comes from ram i
	typedef struct packed
	{
		pix_t [NUM_RAM-1:0] pix;
	} quad_pix_t;

	typedef struct packed
	{
		pix_t data;
		logic last;
	} pix_beat_t;

endpackage

//--- verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
#(
	parameter type T     = logic [7:0],
	parameter int  DEPTH = 8
)
(
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       push,
	input  T                           push_data,
	input  logic                       pop,
	output T                           pop_data,
	output logic                       empty,
	output logic                       full,
	output logic [$clog2(DEPTH+1)-1:0] count
);

	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

	T                 mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign empty   = (count == '0);
	assign full    = (count == CNT_FULL);

	// first word fall-through
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk_sys)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			// simultaneous push and pop leaves count alone
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- verilog/read_sequencer.sv
`timescale 1ns/1ps

module read_sequencer import line_rev_pkg::*;
#(
	parameter int SEG_LEN     = 2040,
	parameter int START_DELAY = 4,
	parameter int FILL_THRESH = 1900,
	parameter int OUT_DEPTH   = 8
)
(
	input  logic                           clk_sys,
	input  logic                           rst_n,
	input  logic                           line_req,
	input  logic                           bank_sel,
	output logic                           line_ack,
	input  logic [11:0]                    fill_level,
	input  logic [$clog2(OUT_DEPTH+1)-1:0] out_count,
	output rd_cmd_t                        cmd,
	output ram_rd_t                        ram_rd,
	input  logic                           drain_done
);

	localparam int CNT_W = $clog2(OUT_DEPTH + 1);
	localparam int DLY_W = (START_DELAY > 1) ? $clog2(START_DELAY) : 1;
	// leaves room for the slots still in flight through the rams
	localparam logic [CNT_W-1:0] SLOT_LIMIT = CNT_W'(OUT_DEPTH - RAM_LAT - 2);
	localparam logic [DLY_W-1:0] DLY_LAST   = DLY_W'(START_DELAY - 1);
	localparam addr_t            REV_FIRST  = ADDR_W'(SEG_LEN - 1);

	seq_state_t       state;
	logic             bank;
	logic [DLY_W-1:0] dly_cnt;
	addr_t            fwd_cnt;
	addr_t            rev_cnt;
	logic             fill_ok;
	logic             drain_pend;
	logic             in_seg;
	logic             go;
	logic             seg_end;

	//////////////////////////////
	// throttle
	//////////////////////////////

	// downstream fill level, compared one cycle late
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			fill_ok <= 1'b0;
		else
			fill_ok <= (fill_level < 12'(FILL_THRESH));
	end

	assign in_seg  = (state == ST_SEG1) || (state == ST_SEG2);
	assign go      = in_seg && fill_ok && (out_count <= SLOT_LIMIT);
	assign seg_end = go && (rev_cnt == '0);

	//////////////////////////////
	// line state machine
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= ST_IDLE;
			bank       <= 1'b0;
			dly_cnt    <= '0;
			fwd_cnt    <= '0;
			rev_cnt    <= REV_FIRST;
			drain_pend <= 1'b0;
			line_ack   <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (line_req)
					begin
						state   <= ST_DELAY;
						bank    <= bank_sel;
						dly_cnt <= '0;
					end
				end
				ST_DELAY:
				begin
					if (dly_cnt == DLY_LAST)
						state <= ST_SEG1;
					else
						dly_cnt <= dly_cnt + 1'b1;
				end
				ST_SEG1, ST_SEG2:
				begin
					if (seg_end)
					begin
						fwd_cnt <= '0;
						rev_cnt <= REV_FIRST;
						if (state == ST_SEG1)
						begin
							state <= ST_SEG2;
						end
						else
						begin
							// drain marker goes out next cycle
							state      <= ST_DRAIN;
							drain_pend <= 1'b1;
						end
					end
					else if (go)
					begin
						fwd_cnt <= fwd_cnt + 1'b1;
						rev_cnt <= rev_cnt - 1'b1;
					end
				end
				ST_DRAIN:
				begin
					drain_pend <= 1'b0;
					if (drain_done)
					begin
						state    <= ST_ACK;
						line_ack <= 1'b1;
					end
				end
				ST_ACK:
				begin
					// four-phase, wait for the requester to let go
					if (!line_req)
					begin
						state    <= ST_IDLE;
						line_ack <= 1'b0;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////
	// slot outputs
	//////////////////////////////

	always_comb
	begin
		cmd.rd       = go;
		cmd.seg      = (state == ST_SEG2);
		cmd.bank     = bank;
		cmd.drain    = (state == ST_DRAIN) && drain_pend;
		cmd.addr_fwd = fwd_cnt;
		cmd.addr_rev = rev_cnt;
	end

	// seg 1 reads rams 0 and 2, seg 2 reads rams 1 and 3
	always_comb
	begin
		ram_rd.en[0]    = go && (state == ST_SEG1);
		ram_rd.en[2]    = go && (state == ST_SEG1);
		ram_rd.en[1]    = go && (state == ST_SEG2);
		ram_rd.en[3]    = go && (state == ST_SEG2);
		ram_rd.bank     = bank;
		ram_rd.addr_fwd = fwd_cnt;
		ram_rd.addr_rev = rev_cnt;
	end

endmodule

//--- verilog/pixel_router.sv
`timescale 1ns/1ps

module pixel_router import line_rev_pkg::*;
#(
	parameter int SEG_LEN = 2040
)
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  rd_cmd_t   cmd,
	input  quad_pix_t rd_data_a,
	input  quad_pix_t rd_data_b,
	output logic      reo_push,
	output pix_t      reo_data,
	output logic      reo_pop,
	input  pix_t      reo_head,
	input  logic      reo_empty,
	output logic      out_push,
	output pix_beat_t out_data,
	input  logic      out_full,
	output logic      drain_done
);

	localparam int REO_LEN = 2 * SEG_LEN;
	localparam int DCNT_W  = $clog2(REO_LEN + 1);
	localparam logic [DCNT_W-1:0] DCNT_LAST = DCNT_W'(REO_LEN - 1);

	rd_cmd_t [RAM_LAT-1:0] cmd_pipe;
	rd_cmd_t               cmd_al;
	quad_pix_t             quad;
	pix_t                  pix_pri;
	pix_t                  pix_sec;
	logic                  draining;
	logic [DCNT_W-1:0]     drain_cnt;
	logic                  drain_last;

	//////////////////////////////
	// latency alignment
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cmd_pipe <= '0;
		end
		else
		begin
			cmd_pipe[0] <= cmd;
			for (int i = 1; i < RAM_LAT; i++)
				cmd_pipe[i] <= cmd_pipe[i-1];
		end
	end

	// cmd_al lines up with the ram data
	assign cmd_al = cmd_pipe[RAM_LAT-1];
	assign quad   = cmd_al.bank ? rd_data_b : rd_data_a;

	// primary is ram 0 or 1, secondary is ram 2 or 3
	assign pix_pri = quad.pix[{1'b0, cmd_al.seg}];
	assign pix_sec = quad.pix[{1'b1, cmd_al.seg}];

	//////////////////////////////
	// routing and drain
	//////////////////////////////

	assign reo_push   = cmd_al.rd;
	assign reo_data   = pix_sec;
	assign reo_pop    = draining && !out_full && !reo_empty;
	assign drain_last = (drain_cnt == DCNT_LAST);
	assign out_push   = cmd_al.rd || reo_pop;

	always_comb
	begin
		if (draining)
		begin
			out_data.data = reo_head;
			out_data.last = drain_last;
		end
		else
		begin
			out_data.data = pix_pri;
			out_data.last = 1'b0;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			draining   <= 1'b0;
			drain_cnt  <= '0;
			drain_done <= 1'b0;
		end
		else
		begin
			drain_done <= 1'b0;
			if (cmd_al.drain)
			begin
				draining  <= 1'b1;
				drain_cnt <= '0;
			end
			else if (reo_pop)
			begin
				// final reordered pixel closes the line
				if (drain_last)
				begin
					draining   <= 1'b0;
					drain_done <= 1'b1;
				end
				else
				begin
					drain_cnt <= drain_cnt + 1'b1;
				end
			end
		end
	end

endmodule

//--- verilog/line_reverse_top.sv
`timescale 1ns/1ps

module line_reverse_top import line_rev_pkg::*;
#(
	parameter int SEG_LEN     = 2040,
	parameter int START_DELAY = 4,
	parameter int FILL_THRESH = 1900,
	parameter int OUT_DEPTH   = 8
)
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      line_req,
	input  logic      bank_sel,
	output logic      line_ack,
	input  logic [11:0] fill_level,
	output ram_rd_t   ram_rd,
	input  quad_pix_t rd_data_a,
	input  quad_pix_t rd_data_b,
	output logic      out_valid,
	input  logic      out_ready,
	output pix_beat_t out_beat
);

	// reorder buffer holds both reversed segments
	localparam int REO_DEPTH = 2 * SEG_LEN;
	localparam int OCNT_W    = $clog2(OUT_DEPTH + 1);

	rd_cmd_t           cmd;
	logic              drain_done;
	logic              reo_push;
	pix_t              reo_data;
	logic              reo_pop;
	pix_t              reo_head;
	logic              reo_empty;
	logic              out_push;
	pix_beat_t         out_data;
	logic              out_full;
	logic              out_empty;
	logic [OCNT_W-1:0] out_count;

	read_sequencer #(
		.SEG_LEN     (SEG_LEN),
		.START_DELAY (START_DELAY),
		.FILL_THRESH (FILL_THRESH),
		.OUT_DEPTH   (OUT_DEPTH)
	) u_seq (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.line_req   (line_req),
		.bank_sel   (bank_sel),
		.line_ack   (line_ack),
		.fill_level (fill_level),
		.out_count  (out_count),
		.cmd        (cmd),
		.ram_rd     (ram_rd),
		.drain_done (drain_done)
	);

	pixel_router #(
		.SEG_LEN (SEG_LEN)
	) u_router (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cmd        (cmd),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.reo_push   (reo_push),
		.reo_data   (reo_data),
		.reo_pop    (reo_pop),
		.reo_head   (reo_head),
		.reo_empty  (reo_empty),
		.out_push   (out_push),
		.out_data   (out_data),
		.out_full   (out_full),
		.drain_done (drain_done)
	);

	sync_fifo #(
		.T     (pix_t),
		.DEPTH (REO_DEPTH)
	) reorder_fifo (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.push      (reo_push),
		.push_data (reo_data),
		.pop       (reo_pop),
		.pop_data  (reo_head),
		.empty     (reo_empty),
		.full      (),
		.count     ()
	);

	sync_fifo #(
		.T     (pix_beat_t),
		.DEPTH (OUT_DEPTH)
	) out_fifo (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.push      (out_push),
		.push_data (out_data),
		.pop       (out_ready),
		.pop_data  (out_beat),
		.empty     (out_empty),
		.full      (out_full),
		.count     (out_count)
	);

	assign out_valid = !out_empty;

endmodule

//--- test/line_ram_model.sv
`timescale 1ns/1ps

module line_ram_model import line_rev_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  ram_rd_t   ram_rd,
	output quad_pix_t rd_data_a,
	output quad_pix_t rd_data_b
);

	// lane value while a ram is not read or the other bank is selected
	localparam pix_t IDLE_PIX = 8'hff;

	quad_pix_t [RAM_LAT-1:0] pipe_a;
	quad_pix_t [RAM_LAT-1:0] pipe_b;
	quad_pix_t               word_a;
	quad_pix_t               word_b;

	// ram id, bank, address modulo 32
	function automatic pix_t cell_value(input int ram, input logic bank, input addr_t addr);
		return {2'(ram), bank, addr[4:0]};
	endfunction

	// rams 0 and 1 are read forward, rams 2 and 3 in reverse
	always_comb
	begin
		for (int i = 0; i < NUM_RAM; i++)
		begin
			word_a.pix[i] = IDLE_PIX;
			word_b.pix[i] = IDLE_PIX;
			if (ram_rd.en[i] && !ram_rd.bank)
				word_a.pix[i] = cell_value(i, 1'b0, (i < 2) ? ram_rd.addr_fwd : ram_rd.addr_rev);
			if (ram_rd.en[i] && ram_rd.bank)
				word_b.pix[i] = cell_value(i, 1'b1, (i < 2) ? ram_rd.addr_fwd : ram_rd.addr_rev);
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pipe_a <= '0;
			pipe_b <= '0;
		end
		else
		begin
			pipe_a[0] <= word_a;
			pipe_b[0] <= word_b;
			for (int i = 1; i < RAM_LAT; i++)
			begin
				pipe_a[i] <= pipe_a[i-1];
				pipe_b[i] <= pipe_b[i-1];
			end
		end
	end

	assign rd_data_a = pipe_a[RAM_LAT-1];
	assign rd_data_b = pipe_b[RAM_LAT-1];

endmodule

//--- test/tb_line_reverse.sv
`timescale 1ns/1ps

module tb_line_reverse import line_rev_pkg::*;
();

	localparam int SEG_LEN      = 12;
	localparam int START_DELAY  = 4;
	localparam int FILL_THRESH  = 1900;
	localparam int OUT_DEPTH    = 8;
	localparam int NUM_TESTS    = 6;
	localparam int LINE_TIMEOUT = 2000;
	localparam int BLOCK_CYCLES = 50;
	localparam int unsigned RAND_SEED = 32'h4bf2_c223;

	localparam logic [1:0] READY_ALWAYS = 2'd0;
	localparam logic [1:0] READY_RANDOM = 2'd1;
	localparam logic [1:0] READY_STALL  = 2'd2;

	typedef struct packed
	{
		logic        bank;
		logic [11:0] fill;
		logic [1:0]  mode;
		logic [15:0] beats;
	} test_row_t;

	logic        clk_sys;
	logic        rst_n;
	logic        line_req;
	logic        bank_sel;
	logic        line_ack;
	logic [11:0] fill_level;
	ram_rd_t     ram_rd;
	quad_pix_t   rd_data_a;
	quad_pix_t   rd_data_b;
	logic        out_valid;
	logic        out_ready;
	pix_beat_t   out_beat;

	test_row_t   table_rows [NUM_TESTS];
	int          err_count;
	int          check_count;
	logic        timed_out;

	line_reverse_top #(
		.SEG_LEN     (SEG_LEN),
		.START_DELAY (START_DELAY),
		.FILL_THRESH (FILL_THRESH),
		.OUT_DEPTH   (OUT_DEPTH)
	) UUT (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.line_req   (line_req),
		.bank_sel   (bank_sel),
		.line_ack   (line_ack),
		.fill_level (fill_level),
		.ram_rd     (ram_rd),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_beat   (out_beat)
	);

	line_ram_model u_rams (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ram_rd    (ram_rd),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// ram 0 and ram 1 forward, then ram 2 and ram 3 reversed
	function automatic pix_beat_t expected_beat(input logic bank, input int idx);
		int        grp;
		int        pos;
		int        addr;
		pix_beat_t beat;
		grp = idx / SEG_LEN;
		pos = idx % SEG_LEN;
		addr = (grp < 2) ? pos : SEG_LEN - 1 - pos;
		beat.data = {grp[1:0], bank, addr[4:0]};
		beat.last = (idx == 4 * SEG_LEN - 1);
		return beat;
	endfunction

	function automatic logic ready_for(input logic [1:0] mode, input int cyc);
		if (mode == READY_RANDOM)
			return ($urandom & 32'h3) != 0;
		// long enough to fill the output fifo during the reads
		if (mode == READY_STALL)
			return !(cyc >= 20 && cyc < 60);
		return 1'b1;
	endfunction

	function automatic string mode_name(input logic [1:0] mode);
		case (mode)
			READY_RANDOM: return "random";
			READY_STALL:  return "stall";
			default:      return "always";
		endcase
	endfunction

	task automatic load_table();
		table_rows[0] = '{1'b0, 12'd0,    READY_ALWAYS, 16'(4 * SEG_LEN)};
		table_rows[1] = '{1'b1, 12'd0,    READY_ALWAYS, 16'(4 * SEG_LEN)};
		table_rows[2] = '{1'b0, 12'd0,    READY_RANDOM, 16'(4 * SEG_LEN)};
		table_rows[3] = '{1'b1, 12'd1900, READY_ALWAYS, 16'(4 * SEG_LEN)};
		table_rows[4] = '{1'b0, 12'd0,    READY_STALL,  16'(4 * SEG_LEN)};
		table_rows[5] = '{1'b1, 12'd100,  READY_RANDOM, 16'(4 * SEG_LEN)};
	endtask

	//////////////////////////////
	// one line per table row
	//////////////////////////////

	task automatic run_line(input int t);
		test_row_t row;
		pix_beat_t exp_beat;
		int        beats;
		int        got;
		int        cyc;
		int        errs_before;
		logic      ack_seen;
		logic      ack_dropped;
		row = table_rows[t];
		beats = int'(row.beats);
		errs_before = err_count;
		got = 0;
		cyc = 0;
		ack_seen = 1'b0;
		ack_dropped = 1'b0;
		@(negedge clk_sys);
		bank_sel = row.bank;
		fill_level = row.fill;
		line_req = 1'b1;
		out_ready = 1'b1;
		// fill level at threshold holds the sequencer off
		if (int'(row.fill) >= FILL_THRESH)
		begin
			for (int i = 0; i < BLOCK_CYCLES; i++)
			begin
				@(negedge clk_sys);
				check_value("out_valid", 32'(out_valid), 32'd0);
				check_value("ram_rd.en", 32'(ram_rd.en), 32'd0);
			end
			fill_level = 12'd0;
		end
		while (!(got >= beats && ack_dropped) && !timed_out)
		begin
			@(negedge clk_sys);
			cyc++;
			if (cyc > LINE_TIMEOUT)
			begin
				$display("timeout: line %0d stopped after %0d of %0d beats", t, got, beats);
				timed_out = 1'b1;
			end
			else
			begin
				out_ready = ready_for(row.mode, cyc);
				if (line_ack && !ack_seen)
				begin
					ack_seen = 1'b1;
					// the rest of the line must already be queued
					if ((got < beats && !out_valid) || (beats - got > OUT_DEPTH))
					begin
						err_count++;
						$display("line_ack rose with %0d beats of line %0d not queued yet",
							beats - got, t);
					end
					line_req = 1'b0;
				end
				else if (ack_seen && !line_ack)
				begin
					ack_dropped = 1'b1;
				end
				if (ack_seen)
					check_value("ram_rd.en", 32'(ram_rd.en), 32'd0);
				if (out_valid && out_ready)
				begin
					if (got >= beats)
					begin
						err_count++;
						$display("line %0d sent a beat after its last one", t);
					end
					else
					begin
						exp_beat = expected_beat(row.bank, got);
						check_value("out_beat.data", 32'(out_beat.data), 32'(exp_beat.data));
						check_value("out_beat.last", 32'(out_beat.last), 32'(exp_beat.last));
					end
					got++;
				end
			end
		end
		if (!timed_out)
		begin
			@(negedge clk_sys);
			check_value("out_valid", 32'(out_valid), 32'd0);
			check_value("line_ack", 32'(line_ack), 32'd0);
		end
		$display("test %0d bank %0d ready %s fill %0d: %0d beats, %0d errors",
			t, row.bank, mode_name(row.mode), row.fill, got, err_count - errs_before);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial
	begin
		rst_n = 1'b0;
		line_req = 1'b0;
		bank_sel = 1'b0;
		fill_level = 12'd0;
		out_ready = 1'b0;
		err_count = 0;
		check_count = 0;
		timed_out = 1'b0;
		void'($urandom(RAND_SEED));
		load_table();
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		// quiet outputs right after reset
		@(negedge clk_sys);
		check_value("out_valid", 32'(out_valid), 32'd0);
		check_value("line_ack", 32'(line_ack), 32'd0);
		check_value("ram_rd.en", 32'(ram_rd.en), 32'd0);
		for (int t = 0; t < NUM_TESTS && !timed_out; t++)
			run_line(t);
		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS, check_count, err_count);
		if (err_count == 0 && !timed_out)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- line_reverse_top.f
verilog/line_rev_pkg.sv
verilog/sync_fifo.sv
verilog/read_sequencer.sv
verilog/pixel_router.sv
verilog/line_reverse_top.sv
test/line_ram_model.sv
test/tb_line_reverse.sv

//--- Makefile
SRCS := $(wildcard verilog/*.sv test/*.sv)

obj_dir/Vtb_line_reverse: $(SRCS) line_reverse_top.f
	verilator --binary --timing --top-module tb_line_reverse -f line_reverse_top.f

run: obj_dir/Vtb_line_reverse
	./obj_dir/Vtb_line_reverse | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
